//--- list.f
+incdir+.
tcu_pkg.sv
tcu_pipe_reg.sv
tcu_lane_mul.sv
tcu_fedp.sv
tcu_tile.sv
tcu_sva.sv
tcu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the tile testbench with verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -f list.f --top-module tcu_tb -Mdir obj_dir \
    > build.log 2>&1 \
    && ./obj_dir/Vtcu_tb > sim.log 2>&1 \
    || echo "build or simulation stopped early, see build.log and sim.log"

grep -q "^Verification passed$" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
exit 0

//--- tcu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcu_params.svh"

module tcu_tb;

    localparam int N         = `TCU_N;
    localparam int COLS      = `TCU_COLS;
    localparam int W         = `TCU_W;
    localparam int DRAIN_MAX = 10 * `TCU_LAT;

    logic                          clk;
    logic                          rst_n;
    logic                          enable;
    logic                          in_valid;
    tcu_pkg::tcu_fmt_e             fmt;
    logic [N-1:0][W-1:0]           a_row;
    logic [COLS-1:0][N-1:0][W-1:0] b_cols;
    logic [COLS-1:0][W-1:0]        c_vals;
    wire                           out_valid;
    wire  [COLS-1:0][W-1:0]        d_vals;

    // operands staged for the next falling edge
    logic [N-1:0][W-1:0]           nx_a;
    logic [COLS-1:0][N-1:0][W-1:0] nx_b;
    logic [COLS-1:0][W-1:0]        nx_c;

    logic [COLS-1:0][W-1:0] exp_q [$];
    logic [31:0]            lfsr;
    logic                   adv;
    int                     errors;
    int                     checks;
    int                     n_in;
    int                     n_out;

    tcu_tile i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .in_valid  (in_valid),
        .fmt       (fmt),
        .a_row     (a_row),
        .b_cols    (b_cols),
        .c_vals    (c_vals),
        .out_valid (out_valid),
        .d_vals    (d_vals)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // one column: split words into elements, extend, multiply, add with wrap
    function automatic logic [W-1:0] ref_dot(input tcu_pkg::tcu_fmt_e f,
                                             input logic [N-1:0][W-1:0] a,
                                             input logic [N-1:0][W-1:0] b,
                                             input logic [W-1:0] c);
        int           ew;
        bit           sgn;
        int           ea;
        int           eb;
        logic [W-1:0] mask;
        logic [W-1:0] acc;
        acc = c;
        case (f)
            tcu_pkg::I8,
            tcu_pkg::U8: ew = 8;
            tcu_pkg::I4,
            tcu_pkg::U4: ew = 4;
            default: return c;
        endcase
        sgn  = (f == tcu_pkg::I8) || (f == tcu_pkg::I4);
        mask = (32'd1 << ew) - 32'd1;
        for (int l = 0; l < N; l++) begin
            for (int k = 0; k < W / ew; k++) begin
                ea = int'((a[l] >> (k * ew)) & mask);
                eb = int'((b[l] >> (k * ew)) & mask);
                if (sgn && ea >= (1 << (ew - 1))) ea = ea - (1 << ew);
                if (sgn && eb >= (1 << (ew - 1))) eb = eb - (1 << ew);
                acc = acc + ea * eb;
            end
        end
        return acc;
    endfunction

    function automatic logic [COLS-1:0][W-1:0] ref_tile();
        logic [COLS-1:0][W-1:0] d;
        for (int c = 0; c < COLS; c++) begin
            d[c] = ref_dot(fmt, a_row, b_cols[c], c_vals[c]);
        end
        return d;
    endfunction

    // sample accepted on this edge
    always @(posedge clk) begin
        adv = enable;
        if (enable && in_valid) begin
            exp_q.push_back(ref_tile());
            n_in++;
        end
    end

    // results are checked half a cycle after the edge that produced them
    always @(negedge clk) begin : check_results
        logic [COLS-1:0][W-1:0] want;
        if (adv && out_valid) begin
            n_out++;
            assert (exp_q.size() != 0) else begin
                $display("out_valid raised at %0t with no sample outstanding", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                for (int c = 0; c < COLS; c++) begin
                    checks++;
                    assert (d_vals[c] == want[c]) else begin
                        $display("ERR %0t: column %0d got %h, expected %h",
                                 $time, c, d_vals[c], want[c]);
                        errors++;
                    end
                end
            end
        end
    end

    task automatic issue(input logic en, input logic vld, input tcu_pkg::tcu_fmt_e f);
        @(negedge clk);
        enable   = en;
        in_valid = vld;
        fmt      = f;
        a_row    = nx_a;
        b_cols   = nx_b;
        c_vals   = nx_c;
    endtask

    task automatic random_operands();
        for (int l = 0; l < N; l++) begin
            nx_a[l] = rand_bits(W);
        end
        for (int c = 0; c < COLS; c++) begin
            for (int l = 0; l < N; l++) begin
                nx_b[c][l] = rand_bits(W);
            end
            nx_c[c] = rand_bits(W);
        end
    endtask

    function automatic tcu_pkg::tcu_fmt_e random_fmt();
        return tcu_pkg::tcu_fmt_e'(4'h8 | 4'(rand_bits(2)));
    endfunction

    task automatic start_test();
        n_in  = 0;
        n_out = 0;
    endtask

    task automatic finish_test(input int num, input string name);
        int t;
        t = 0;
        do begin
            issue(1'b1, 1'b0, fmt);
            t++;
        end while (exp_q.size() != 0 && t < DRAIN_MAX);
        assert (exp_q.size() == 0) else begin
            $display("test %0d timed out with %0d results missing", num, exp_q.size());
            errors++;
        end
        assert (n_out == n_in) else begin
            $display("test %0d gave %0d results for %0d samples", num, n_out, n_in);
            errors++;
        end
        $display("test %0d %s: %0d samples, %0d results, %0d errors so far",
                 num, name, n_in, n_out, errors);
    endtask

    initial begin
        lfsr     = 32'h3a772f86;
        errors   = 0;
        checks   = 0;
        n_in     = 0;
        n_out    = 0;
        adv      = 1'b0;
        rst_n    = 1'b0;
        enable   = 1'b0;
        in_valid = 1'b0;
        fmt      = tcu_pkg::I8;
        a_row    = '0;
        b_cols   = '0;
        c_vals   = '0;
        nx_a     = '0;
        nx_b     = '0;
        nx_c     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test();
        for (int i = 0; i < 8; i++) begin
            random_operands();
            issue(1'b1, 1'b1, tcu_pkg::I8);
        end
        // -128 and 127 in every position
        nx_a = {N{32'h807f_807f}};
        nx_b = {COLS{{N{32'h8080_7f7f}}}};
        issue(1'b1, 1'b1, tcu_pkg::I8);
        nx_a = {N{32'h8080_8080}};
        nx_b = {COLS{{N{32'h8080_8080}}}};
        issue(1'b1, 1'b1, tcu_pkg::I8);
        finish_test(1, "signed 8-bit");

        start_test();
        nx_a = {N{32'hffff_ffff}};
        nx_b = {COLS{{N{32'hffff_ffff}}}};
        nx_c = {32'hfff0_0000, 32'hffff_ff00};
        issue(1'b1, 1'b1, tcu_pkg::U8);
        nx_c = {32'hffff_ffff, 32'hffff_e3e0};
        issue(1'b1, 1'b1, tcu_pkg::U4);
        for (int i = 0; i < 6; i++) begin
            random_operands();
            issue(1'b1, 1'b1, (i % 2 == 0) ? tcu_pkg::U8 : tcu_pkg::U4);
        end
        finish_test(2, "unsigned 8-bit and 4-bit");

        start_test();
        nx_a    = {N{32'h8888_8888}};
        nx_b[0] = {N{32'hffff_ffff}};
        nx_b[1] = {N{32'h7777_7777}};
        nx_c    = {32'h0000_1000, 32'h8000_0000};
        issue(1'b1, 1'b1, tcu_pkg::I4);
        for (int i = 0; i < 8; i++) begin
            random_operands();
            // force the sign bit of every A nibble
            for (int l = 0; l < N; l++) begin
                nx_a[l] = nx_a[l] | 32'h8888_8888;
            end
            issue(1'b1, 1'b1, tcu_pkg::I4);
        end
        finish_test(3, "signed 4-bit per column");

        start_test();
        for (int i = 0; i < 20; i++) begin
            random_operands();
            issue(1'b1, 1'b1, random_fmt());
        end
        finish_test(4, "back-to-back burst");

        start_test();
        for (int i = 0; i < 40; i++) begin
            random_operands();
            issue(rand_bits(2) != 32'd0, rand_bits(1) != 32'd0, random_fmt());
        end
        finish_test(5, "stalls and gaps");

        start_test();
        random_operands();
        issue(1'b1, 1'b1, tcu_pkg::tcu_fmt_e'(4'h0));
        random_operands();
        issue(1'b1, 1'b1, tcu_pkg::tcu_fmt_e'(4'h3));
        random_operands();
        issue(1'b1, 1'b1, tcu_pkg::tcu_fmt_e'(4'h7));
        random_operands();
        issue(1'b1, 1'b1, tcu_pkg::tcu_fmt_e'(4'hf));
        finish_test(6, "undefined format");

        errors += i_dut.i_sva.fail_cnt;
        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tcu_sva.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcu_params.svh"

module tcu_sva (
    input wire                                clk,
    input wire                                rst_n,
    input wire                                enable,
    input wire                                in_valid,
    input wire                                out_valid,
    input wire [`TCU_COLS-1:0][`TCU_W-1:0]    d_vals
);

    // valid samples taken on enabled edges, oldest in the top bit
    logic [`TCU_LAT-1:0] vhist;

    // assertion failures seen so far
    int fail_cnt = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vhist <= '0;
        end else if (enable) begin
            vhist <= {vhist[`TCU_LAT-2:0], in_valid};
        end
    end

    // nothing comes out while reset is held
    a_reset_low: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            $error("out_valid high while rst_n is low");
            fail_cnt++;
        end

    // out_valid exactly four enabled edges after an accepted sample
    a_valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == vhist[`TCU_LAT-1]
    ) else begin
        $error("out_valid does not follow in_valid by four enabled edges");
        fail_cnt++;
    end

    // a stalled edge changes nothing at the outputs
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        !enable |=> ($stable(out_valid) && $stable(d_vals))
    ) else begin
        $error("outputs moved during a stall");
        fail_cnt++;
    end

endmodule

bind tcu_tile tcu_sva i_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .d_vals    (d_vals)
);

`default_nettype wire

//--- tcu_tile.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcu_params.svh"

module tcu_tile #(
    parameter int N    = `TCU_N,
    parameter int COLS = `TCU_COLS
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                enable,
    input  wire                                in_valid,
    input  wire tcu_pkg::tcu_fmt_e             fmt,
    input  wire [N-1:0][`TCU_W-1:0]            a_row,
    input  wire [COLS-1:0][N-1:0][`TCU_W-1:0]  b_cols,
    input  wire [COLS-1:0][`TCU_W-1:0]         c_vals,
    output wire                                out_valid,
    output wire [COLS-1:0][`TCU_W-1:0]         d_vals
);

    // one dot-product unit per column, A row and format broadcast
    for (genvar c = 0; c < COLS; c++) begin : g_col
        tcu_fedp #(
            .N (N)
        ) i_fedp (
            .clk    (clk),
            .rst_n  (rst_n),
            .enable (enable),
            .fmt    (fmt),
            .a_row  (a_row),
            .b_col  (b_cols[c]),
            .c_val  (c_vals[c]),
            .d_val  (d_vals[c])
        );
    end

    // valid follows the data through both stages
    tcu_pipe_reg #(
        .DATAW  (1),
        .DEPTH  (`TCU_LAT),
        .RESETW (1)
    ) i_pipe_valid (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  (in_valid),
        .data_out (out_valid)
    );

endmodule

`default_nettype wire

//--- tcu_fedp.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcu_params.svh"

module tcu_fedp #(
    parameter int N = `TCU_N
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        enable,
    input  wire tcu_pkg::tcu_fmt_e     fmt,
    input  wire [N-1:0][`TCU_W-1:0]    a_row,
    input  wire [N-1:0][`TCU_W-1:0]    b_col,
    input  wire [`TCU_W-1:0]           c_val,
    output wire [`TCU_W-1:0]           d_val
);

    localparam int FMTW = $bits(tcu_pkg::tcu_fmt_e);

    wire  [N-1:0][`TCU_W-1:0] lane_psum;
    wire  [N-1:0][`TCU_W-1:0] prod_dly;
    wire  [FMTW-1:0]          fmt_dly;
    wire  [`TCU_W-1:0]        c_dly;
    logic [`TCU_W-1:0]        acc;

    // multiply stage
    for (genvar i = 0; i < N; i++) begin : g_lane
        tcu_lane_mul i_mul (
            .fmt    (fmt),
            .a_word (a_row[i]),
            .b_word (b_col[i]),
            .psum   (lane_psum[i])
        );
    end

    tcu_pipe_reg #(
        .DATAW  (N * `TCU_W),
        .DEPTH  (`TCU_MUL_LAT),
        .RESETW (0)
    ) i_pipe_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  (lane_psum),
        .data_out (prod_dly)
    );

    // format and addend ride alongside the products
    tcu_pipe_reg #(
        .DATAW  (FMTW + `TCU_W),
        .DEPTH  (`TCU_MUL_LAT),
        .RESETW (0)
    ) i_pipe_c (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  ({fmt, c_val}),
        .data_out ({fmt_dly, c_dly})
    );

    // wrapping sum of lanes plus addend
    always_comb begin
        acc = c_dly;
        case (tcu_pkg::tcu_fmt_e'(fmt_dly))
            tcu_pkg::I8,
            tcu_pkg::U8,
            tcu_pkg::I4,
            tcu_pkg::U4: begin
                for (int i = 0; i < N; i++) begin
                    acc = acc + prod_dly[i];
                end
            end
            default: acc = c_dly;
        endcase
    end

    // accumulate stage
    tcu_pipe_reg #(
        .DATAW  (`TCU_W),
        .DEPTH  (`TCU_ACC_LAT),
        .RESETW (0)
    ) i_pipe_acc (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  (acc),
        .data_out (d_val)
    );

endmodule

`default_nettype wire

//--- tcu_lane_mul.sv
`timescale 1ns/10ps
`default_nettype none

`include "tcu_params.svh"

module tcu_lane_mul (
    input  wire tcu_pkg::tcu_fmt_e fmt,
    input  wire [`TCU_W-1:0]       a_word,
    input  wire [`TCU_W-1:0]       b_word,
    output wire [`TCU_W-1:0]       psum
);

    logic              sgn;
    logic              nibble;
    logic              known;
    logic signed [8:0]  ea;
    logic signed [8:0]  eb;
    logic signed [17:0] prod;
    logic [`TCU_W-1:0]  sum;

    // format decode
    always_comb begin
        sgn    = 1'b0;
        nibble = 1'b0;
        known  = 1'b1;
        case (fmt)
            tcu_pkg::I8: sgn = 1'b1;
            tcu_pkg::U8: sgn = 1'b0;
            tcu_pkg::I4: begin
                sgn    = 1'b1;
                nibble = 1'b1;
            end
            tcu_pkg::U4: nibble = 1'b1;
            default: known = 1'b0;
        endcase
    end

    // every element widened to 9 bits signed, so one multiplier covers all formats
    always_comb begin
        sum  = '0;
        ea   = '0;
        eb   = '0;
        prod = '0;
        if (nibble) begin
            for (int j = 0; j < 8; j++) begin
                ea   = {{5{sgn & a_word[4*j+3]}}, a_word[4*j +: 4]};
                eb   = {{5{sgn & b_word[4*j+3]}}, b_word[4*j +: 4]};
                prod = ea * eb;
                sum  = sum + {{14{prod[17]}}, prod};
            end
        end else begin
            for (int j = 0; j < 4; j++) begin
                ea   = {sgn & a_word[8*j+7], a_word[8*j +: 8]};
                eb   = {sgn & b_word[8*j+7], b_word[8*j +: 8]};
                prod = ea * eb;
                sum  = sum + {{14{prod[17]}}, prod};
            end
        end
    end

    // unknown codes contribute nothing
    assign psum = known ? sum : '0;

endmodule

`default_nettype wire

//--- tcu_pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module tcu_pipe_reg #(
    parameter int DATAW  = 1,
    parameter int DEPTH  = 1,
    parameter int RESETW = 0
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             enable,
    input  wire [DATAW-1:0] data_in,
    output wire [DATAW-1:0] data_out
);

    if (DEPTH == 0) begin : g_wire
        assign data_out = data_in;
    end else begin : g_regs
        // low bits carry control and are cleared on reset
        if (RESETW > 0) begin : g_ctrl
            logic [RESETW-1:0] ctrl_q [DEPTH];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < DEPTH; s++) begin
                        ctrl_q[s] <= '0;
                    end
                end else if (enable) begin
                    ctrl_q[0] <= data_in[RESETW-1:0];
                    for (int s = 1; s < DEPTH; s++) begin
                        ctrl_q[s] <= ctrl_q[s-1];
                    end
                end
            end

            assign data_out[RESETW-1:0] = ctrl_q[DEPTH-1];
        end

        // payload bits just shift
        if (RESETW < DATAW) begin : g_data
            logic [DATAW-1:RESETW] data_q [DEPTH];

            always_ff @(posedge clk) begin
                if (enable) begin
                    data_q[0] <= data_in[DATAW-1:RESETW];
                    for (int s = 1; s < DEPTH; s++) begin
                        data_q[s] <= data_q[s-1];
                    end
                end
            end

            assign data_out[DATAW-1:RESETW] = data_q[DEPTH-1];
        end
    end

endmodule

`default_nettype wire

//--- tcu_pkg.sv
`default_nettype none

package tcu_pkg;

    // element formats, integer codes keep bit 3 set
    // float codes of the wider core are not defined here
    typedef enum logic [3:0] {
        I8 = 4'h8,
        U8 = 4'h9,
        I4 = 4'hA,
        U4 = 4'hB
    } tcu_fmt_e;

endpackage

`default_nettype wire

//--- tcu_params.svh
`ifndef TCU_PARAMS_SVH
`define TCU_PARAMS_SVH

// lanes per dot product, one 32-bit word of packed elements each
`define TCU_N 4

// dot-product columns per tile
`define TCU_COLS 2

// multiply stage depth
`define TCU_MUL_LAT 2

// accumulate stage depth
`define TCU_ACC_LAT 2

// input to output, in enabled edges
`define TCU_LAT (`TCU_MUL_LAT + `TCU_ACC_LAT)

// data word width
`define TCU_W 32

`endif
